//--- hw/stream_queue_defines.svh
`ifndef STREAM_QUEUE_DEFINES_SVH
`define STREAM_QUEUE_DEFINES_SVH

// ========================================
// queue geometry
// ========================================

// log2 of the number of storage entries.
`define QUEUE_DEPTH_LOG2 8

// number of storage entries.
`define QUEUE_DEPTH (1 << `QUEUE_DEPTH_LOG2)

// ========================================
// beat format
// ========================================

// bytes carried by one beat.
`define QUEUE_DATA_BYTES 4

// free entries left when almost_full asserts.
// one beat sits in the write register, one more is taken while tready lags.
`define QUEUE_ALMOST_FULL_MARGIN 2

`endif

//--- hw/stream_queue_pkg.sv
`default_nettype none

`include "stream_queue_defines.svh"

package stream_queue_pkg;

    // ========================================
    // payload and pointer widths
    // ========================================

    typedef logic [`QUEUE_DATA_BYTES*8-1:0] data_t;   // beat payload.
    typedef logic [`QUEUE_DATA_BYTES-1:0]   keep_t;   // byte enables.
    typedef logic [`QUEUE_DEPTH_LOG2-1:0]   addr_t;   // memory pointer.
    typedef logic [`QUEUE_DEPTH_LOG2:0]     level_t;  // fill count, extra bit for full.

    // ========================================
    // stream beat
    // ========================================

    typedef struct packed {
        data_t data;    // tdata.
        keep_t keep;    // tkeep.
        logic  last;    // tlast.
    } beat_t;

    // how many beats the output buffer holds.
    typedef enum logic [1:0] {
        TX_EMPTY,
        TX_ONE,
        TX_TWO
    } tx_state_e;

endpackage

`default_nettype wire

//--- hw/stream_rx_stage.sv
`timescale 1ns/100ps
`default_nettype none

module stream_rx_stage
    import stream_queue_pkg::*;
(
    input  wire logic  aclk,
    input  wire logic  areset_n,
    // receive stream port
    input  wire logic  rx_tvalid,
    output logic       rx_tready,
    input  wire beat_t rx_beat,
    // storage write side
    input  wire logic  almost_full,
    output logic       wr_en,
    output beat_t      wr_beat
);

    // ========================================
    // write strobe
    // ========================================

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_en <= 1'b0;
        end
        else begin
            wr_en <= rx_tvalid && rx_tready;  // one pulse per accepted beat.
        end
    end

    // payload follows the strobe by the same cycle.
    always_ff @(posedge aclk) begin
        wr_beat <= rx_beat;
    end

    // ========================================
    // flow control
    // ========================================

    // tready lags almost_full by one cycle; the storage margin absorbs the
    // beats that still get through in that window.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_tready <= 1'b0;
        end
        else begin
            rx_tready <= !almost_full;
        end
    end

endmodule

`default_nettype wire

//--- hw/queue_storage.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_queue_defines.svh"

module queue_storage
    import stream_queue_pkg::*;
(
    input  wire logic  aclk,
    input  wire logic  areset_n,
    // write side
    input  wire logic  wr_en,
    input  wire beat_t wr_beat,
    // read side
    input  wire logic  rd_en,
    output beat_t      rd_beat,
    // status
    output logic       empty,
    output logic       almost_full
);

    // fill level at which almost_full asserts.
    localparam level_t ALMOST_FULL_LEVEL =
        level_t'(`QUEUE_DEPTH - `QUEUE_ALMOST_FULL_MARGIN);

    beat_t  mem [`QUEUE_DEPTH];  // circular beat store.
    addr_t  wr_ptr;              // next slot to write.
    addr_t  rd_ptr;              // next slot to read.
    level_t level;               // beats currently stored.

    // ========================================
    // memory array
    // ========================================

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // synchronous read, data one cycle after rd_en.
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_ptr];
        end
    end

    // ========================================
    // pointers
    // ========================================

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr <= '0;
        end
        else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth.
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rd_ptr <= '0;
        end
        else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ========================================
    // fill count
    // ========================================

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            level <= '0;
        end
        else begin
            case ({wr_en, rd_en})
                2'b10: begin
                    level <= level + 1'b1;  // write only.
                end
                2'b01: begin
                    level <= level - 1'b1;  // read only.
                end
                default: begin
                    level <= level;         // both or neither.
                end
            endcase
        end
    end

    // ========================================
    // status flags
    // ========================================

    always_comb begin
        empty = (level == '0);
    end

    always_comb begin
        almost_full = (level >= ALMOST_FULL_LEVEL);
    end

endmodule

`default_nettype wire

//--- hw/stream_tx_stage.sv
`timescale 1ns/100ps
`default_nettype none

module stream_tx_stage
    import stream_queue_pkg::*;
(
    input  wire logic  aclk,
    input  wire logic  areset_n,
    // storage read side
    input  wire logic  empty,
    output logic       rd_en,
    input  wire beat_t rd_beat,
    // transmit stream port
    output logic       tx_tvalid,
    input  wire logic  tx_tready,
    output beat_t      tx_beat
);

    tx_state_e state;      // buffered beat count.
    logic      pending;    // read issued last cycle, rd_beat valid now.
    logic      pop;        // head leaves this cycle.
    logic [1:0] held;      // state as a number.
    logic [2:0] occupancy; // beats held or in flight after this cycle.
    beat_t     head;       // beat shown on the port.
    beat_t     second;     // beat waiting behind the head.

    // ========================================
    // read issue
    // ========================================

    always_comb begin
        case (state)
            TX_ONE:  held = 2'd1;
            TX_TWO:  held = 2'd2;
            default: held = 2'd0;
        endcase
    end

    always_comb begin
        pop = tx_tvalid && tx_tready;
    end

    // a beat leaving this cycle frees its slot for a new read.
    always_comb begin
        occupancy = 3'(held) + 3'(pending) - 3'(pop);
        rd_en     = !empty && (occupancy < 3'd2);
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            pending <= 1'b0;
        end
        else begin
            pending <= rd_en;
        end
    end

    // ========================================
    // buffer occupancy
    // ========================================

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= TX_EMPTY;
        end
        else begin
            case (state)
                TX_EMPTY: if (pending)         state <= TX_ONE;
                TX_ONE:   if (pending && !pop) state <= TX_TWO;
                          else if (!pending && pop) state <= TX_EMPTY;
                TX_TWO:   if (pop && !pending) state <= TX_ONE;
                default:  state <= TX_EMPTY;
            endcase
        end
    end

    // ========================================
    // buffer entries
    // ========================================

    always_ff @(posedge aclk) begin
        case (state)
            TX_EMPTY: begin
                if (pending) head <= rd_beat;
            end
            TX_ONE: begin
                if (pending && pop) begin
                    head <= rd_beat;     // arriving beat replaces the head.
                end
                else if (pending) begin
                    second <= rd_beat;   // queue behind a stalled head.
                end
            end
            TX_TWO: begin
                if (pop) begin
                    head <= second;
                    if (pending) second <= rd_beat;
                end
            end
            default: begin
                head <= head;
            end
        endcase
    end

    // ========================================
    // transmit port
    // ========================================

    always_comb begin
        tx_tvalid = (state != TX_EMPTY);
        tx_beat   = head;
    end

endmodule

`default_nettype wire

//--- hw/stream_queue.sv
`timescale 1ns/100ps
`default_nettype none

module stream_queue
    import stream_queue_pkg::*;
(
    input  wire logic  aclk,
    input  wire logic  areset_n,
    // receive stream port
    input  wire logic  rx_tvalid,
    output logic       rx_tready,
    input  wire beat_t rx_beat,
    // transmit stream port
    output logic       tx_tvalid,
    input  wire logic  tx_tready,
    output beat_t      tx_beat
);

    logic  wr_en;        // receive stage to storage.
    beat_t wr_beat;
    logic  almost_full;  // storage back to receive stage.
    logic  rd_en;        // transmit stage to storage.
    beat_t rd_beat;
    logic  empty;        // storage back to transmit stage.

    // ========================================
    // receive, store, transmit
    // ========================================

    stream_rx_stage u_rx (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .rx_tvalid   (rx_tvalid),
        .rx_tready   (rx_tready),
        .rx_beat     (rx_beat),
        .almost_full (almost_full),
        .wr_en       (wr_en),
        .wr_beat     (wr_beat)
    );

    queue_storage u_storage (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .wr_en       (wr_en),
        .wr_beat     (wr_beat),
        .rd_en       (rd_en),
        .rd_beat     (rd_beat),
        .empty       (empty),
        .almost_full (almost_full)
    );

    stream_tx_stage u_tx (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .empty       (empty),
        .rd_en       (rd_en),
        .rd_beat     (rd_beat),
        .tx_tvalid   (tx_tvalid),
        .tx_tready   (tx_tready),
        .tx_beat     (tx_beat)
    );

endmodule

`default_nettype wire

//--- tb/stream_queue_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_queue_defines.svh"

module stream_queue_tb
    import stream_queue_pkg::*;
();

    localparam int MAX_CYCLES = 20000;  // the whole run needs about 3000 cycles.
    localparam int TABLE_SIZE = 1024;   // random payload entries picked by idx[9:0].
    localparam int DRAIN_IDLE = 20;     // quiet output cycles before a drain gives up.
    localparam int READY_HIGH = 0;
    localparam int READY_RAND = 1;
    localparam int READY_LOW  = 2;

    logic  aclk;
    logic  areset_n;
    logic  rx_tvalid;
    logic  rx_tready;
    beat_t rx_beat;
    logic  tx_tvalid;
    logic  tx_tready;
    beat_t tx_beat;

    data_t data_tab [TABLE_SIZE];  // random tdata per sequence index.
    keep_t keep_tab [TABLE_SIZE];  // random tkeep per sequence index.

    beat_t exp_q [$];              // accepted beats not yet delivered.
    int    rx_count   = 0;         // receive transfers seen.
    int    tx_count   = 0;         // transmit transfers seen.
    int    mon_errors = 0;
    int    cycles     = 0;
    logic  stall_prev = 1'b0;      // last cycle ended with tvalid high and tready low.
    beat_t stall_beat;
    int    next_idx;               // next index the stimulus offers.
    int    ready_mode;
    int    seq_errors;

    stream_queue uut (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (rx_tvalid),
        .rx_tready (rx_tready),
        .rx_beat   (rx_beat),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_beat   (tx_beat)
    );

    // ========================================
    // clock and run limit
    // ========================================

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;  // 4 ns period.
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d beats delivered",
                     MAX_CYCLES, tx_count, rx_count);
            $display("tests failed");
            $finish;
        end
    end

    // the sink reads the mode on the edge and applies it 1 ns later.
    initial begin
        int mode_now;
        tx_tready = 1'b0;
        forever begin
            @(posedge aclk);
            mode_now = ready_mode;
            #1;
            case (mode_now)
                READY_RAND: tx_tready = ($urandom_range(99) < 60);
                READY_LOW:  tx_tready = 1'b0;
                default:    tx_tready = 1'b1;
            endcase
        end
    end

    // ========================================
    // reference model
    // ========================================

    function automatic beat_t beat_for_index(input int unsigned idx);
        beat_t b;
        b.data = data_tab[idx[9:0]];
        b.keep = keep_tab[idx[9:0]];
        b.last = (idx[2:0] == 3'd7);  // every eighth beat ends a packet.
        return b;
    endfunction

    // ========================================
    // compare process
    // ========================================

    // sampled mid-cycle, where every input and output is settled.
    always @(negedge aclk) begin
        beat_t expected;
        if (areset_n) begin
            if (stall_prev) begin
                assert (tx_tvalid && tx_beat == stall_beat) else begin
                    $display("** Error at %0t: stalled beat %h changed, now valid %b beat %h",
                             $time, stall_beat, tx_tvalid, tx_beat);
                    mon_errors++;
                end
            end
            assert (!tx_tvalid || exp_q.size() > 0) else begin
                $display("** Error at %0t: tx_tvalid high with no beat outstanding", $time);
                mon_errors++;
            end
            if (rx_tvalid && rx_tready) begin
                exp_q.push_back(beat_for_index(rx_count));
                rx_count++;
            end
            if (tx_tvalid && tx_tready && exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (tx_beat == expected) else begin
                    $display("** Error at %0t: beat %0d is %h, expected %h",
                             $time, tx_count, tx_beat, expected);
                    mon_errors++;
                end
                tx_count++;
            end
            stall_prev = tx_tvalid && !tx_tready;
            stall_beat = tx_beat;
        end
    end

    // ========================================
    // stimulus tasks
    // ========================================

    // offers count beats with idle cycles drawn at gap_pct percent.
    task automatic send_beats(input int count, input int unsigned gap_pct);
        int   sent;
        logic taken;
        sent = 0;
        while (sent < count) begin
            if (!rx_tvalid && ($urandom_range(99) >= gap_pct)) begin
                rx_tvalid = 1'b1;
                rx_beat   = beat_for_index(next_idx);
            end
            taken = rx_tvalid && rx_tready;  // transfer at the coming edge.
            @(posedge aclk);
            #1;
            if (taken) begin
                sent++;
                next_idx++;
                rx_tvalid = 1'b0;
            end
        end
    endtask

    // offers beats back to back until rx_tready has been low 10 cycles.
    task automatic fill_queue(output int accepted);
        int   low_run;
        logic taken;
        accepted = 0;
        low_run  = 0;
        while (low_run < 10) begin
            rx_tvalid = 1'b1;
            rx_beat   = beat_for_index(next_idx);
            taken     = rx_tready;
            if (rx_tready) begin
                low_run = 0;
            end
            else begin
                low_run++;
            end
            @(posedge aclk);
            #1;
            if (taken) begin
                accepted++;
                next_idx++;
            end
        end
        rx_tvalid = 1'b0;
    endtask

    // returns when every accepted beat is out or the output has gone quiet.
    task automatic wait_drained();
        int idle;
        int last_count;
        idle       = 0;
        last_count = tx_count;
        while (tx_count < rx_count && idle < DRAIN_IDLE) begin
            @(posedge aclk);
            #1;
            if (tx_count == last_count) begin
                idle++;
            end
            else begin
                idle       = 0;
                last_count = tx_count;
            end
        end
    endtask

    // ========================================
    // test sequence
    // ========================================

    initial begin
        int seed;
        int ready_wait;
        int accepted;
        seed = 85;
        void'($urandom(seed));
        for (int i = 0; i < TABLE_SIZE; i++) begin
            data_tab[i[9:0]] = $urandom;
            keep_tab[i[9:0]] = keep_t'($urandom_range(15, 1));
        end

        areset_n   = 1'b0;
        rx_tvalid  = 1'b0;
        rx_beat    = '0;
        ready_mode = READY_HIGH;
        next_idx   = 0;
        seq_errors = 0;
        repeat (2) @(posedge aclk);
        #1;
        areset_n = 1'b1;

        // rx_tready comes up while tx stays idle.
        ready_wait = 0;
        while (!rx_tready && ready_wait < 2) begin
            @(posedge aclk);
            #1;
            ready_wait++;
        end
        assert (rx_tready) else begin
            $display("** Error at %0t: rx_tready still low two cycles after reset", $time);
            seq_errors++;
        end
        repeat (5) @(posedge aclk);
        #1;

        // order and content with a free-running sink.
        send_beats(1000, 30);
        wait_drained();

        // random back-pressure.
        ready_mode = READY_RAND;
        send_beats(500, 20);
        ready_mode = READY_HIGH;
        wait_drained();

        // fill with the sink stopped, then drain.
        ready_mode = READY_LOW;
        fill_queue(accepted);
        assert (accepted >= `QUEUE_DEPTH - `QUEUE_ALMOST_FULL_MARGIN &&
                accepted <= `QUEUE_DEPTH + 2) else begin
            $display("** Error at %0t: fill took %0d beats, expected %0d to %0d", $time,
                     accepted, `QUEUE_DEPTH - `QUEUE_ALMOST_FULL_MARGIN, `QUEUE_DEPTH + 2);
            seq_errors++;
        end
        ready_mode = READY_HIGH;
        wait_drained();

        // idle tail where the monitor flags any stray tx_tvalid.
        repeat (20) @(posedge aclk);
        #1;
        assert (exp_q.size() == 0 && tx_count == rx_count) else begin
            $display("** Error at %0t: %0d beats left in the expected queue",
                     $time, exp_q.size());
            seq_errors++;
        end

        $display("beats sent %0d, beats checked %0d, compare errors %0d, sequence errors %0d",
                 rx_count, tx_count, mon_errors, seq_errors);
        if (mon_errors + seq_errors == 0) begin
            $display("all tests passed");
        end
        else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/stream_queue_pkg.sv
hw/stream_rx_stage.sv
hw/queue_storage.sv
hw/stream_tx_stage.sv
hw/stream_queue.sv
tb/stream_queue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the stream queue testbench with Verilator, run it and check the verdict.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    -Wno-fatal \
    --top-module stream_queue_tb \
    -f all.f

sim_output=$(./obj_dir/Vstream_queue_tb)
echo "$sim_output"

if echo "$sim_output" | grep -qx "all tests passed"; then
    echo "simulation PASS"
    exit 0
fi

echo "simulation FAIL"
exit 1
